// ==== opx_settings.svh ====
`ifndef OPX_SETTINGS_SVH
`define OPX_SETTINGS_SVH

// instruction groups, taken from instr[15:14]
`define GROUP_SYSTEM            2'd0
`define GROUP_LOAD_STORE        2'd1
`define GROUP_JUMP              2'd2
`define GROUP_ARITHMETIC_LOGIC  2'd3

`define ALU_OPX_MOV             4'd0
`define ALU_OPX_CMP             4'd7

`define ALUA_SRCX_REG_A         3'd0
`define ALUB_SRCX_REG_B         3'd0
`define ALUB_SRCX_IMM           3'd1

`define ADDR_BUSX_PC_A          2'd0
`define ADDR_BUSX_REG_B         2'd1

`define PC_BASEX_PC_A           2'd0
`define PC_BASEX_REG_B          2'd1
`define PC_OFFSETX_2            2'd1
`define PC_OFFSETX_IMM          2'd2

`define DATA_BUSX_REGA_DOUT     2'd0
`define DATA_BUSX_ALU_R         2'd1
`define DATA_BUSX_MEM           2'd2

`define REGA_ADDRX_ARGA         2'd0
`define REGB_ADDRX_ARGB         3'd0
`define REGA_DINX_DIN           2'd0
`define REGA_DINX_ALU_R         2'd1
`define REGA_DINX_PC            2'd2

`define REG_SEQX_NONE           4'd0
`define REG_SEQX_WRITE_A        4'd1

`define RDX_NONE                1'b0
`define WRX_NONE                1'b0
`define BYTEX_WORD              1'b0

`endif

// ==== opxPkg.sv ====
package opxPkg;

	//////////////////////////////////////////////////////////////////////
	// instruction word
	//////////////////////////////////////////////////////////////////////

	// [15:14] group, [13:10] opcode, [9:8] regA, [7:5] regB, [4] immediate
	typedef logic [15:0] instrT;

	typedef logic [1:0] groupT;

	typedef logic [3:0] opcodeT;

	//////////////////////////////////////////////////////////////////////
	// control field codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] aluOpT;

	// alu A and B operand sources
	typedef logic [2:0] srcSelT;

	// address bus, data bus, pc base, pc offset, regA address and data in
	typedef logic [1:0] busSelT;

	typedef logic [2:0] regBSelT;

	// register file sequence code
	typedef logic [3:0] regSeqT;

	//////////////////////////////////////////////////////////////////////
	// phase sequencer
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		phFetch,
		phExecute
	} phaseT;

endpackage

// ==== opxBundleIf.sv ====
`timescale 1ns/1ns

interface opxBundleIf;
	import opxPkg::*;

	busSelT  addrBus;
	aluOpT   aluOp;
	srcSelT  aluASrc;
	srcSelT  aluBSrc;
	logic    byteSel;
	logic    cclLoad;
	busSelT  dataBus;
	busSelT  pcBase;
	busSelT  pcOffset;
	logic    rd;
	busSelT  regAAddr;
	busSelT  regADin;
	regSeqT  regSeq;
	regBSelT regBAddr;
	logic    wr;

	modport decoder (
		output addrBus, aluOp, aluASrc, aluBSrc, byteSel, cclLoad, dataBus, pcBase,
			pcOffset, rd, regAAddr, regADin, regSeq, regBAddr, wr
	);

	modport mux (
		input addrBus, aluOp, aluASrc, aluBSrc, byteSel, cclLoad, dataBus, pcBase,
			pcOffset, rd, regAAddr, regADin, regSeq, regBAddr, wr
	);

endinterface

// ==== aluGroupDecoder.sv ====
`timescale 1ns/1ns
`include "opx_settings.svh"

module aluGroupDecoder (
	input opxPkg::instrT instrReg,
	opxBundleIf.decoder bundle
);
	import opxPkg::*;

	opcodeT opcode;
	logic immFlag;

	assign opcode = instrReg[13:10];
	assign immFlag = instrReg[4];

	always_comb begin
		bundle.aluOp = opcode; // opcode is the alu operation directly
		bundle.aluASrc = `ALUA_SRCX_REG_A;
		bundle.aluBSrc = immFlag ? `ALUB_SRCX_IMM : `ALUB_SRCX_REG_B;
		bundle.cclLoad = (opcode != `ALU_OPX_MOV); // mov leaves flags alone

		// compare only sets flags, no writeback
		if (opcode == `ALU_OPX_CMP) begin
			bundle.regSeq = `REG_SEQX_NONE;
		end else begin
			bundle.regSeq = `REG_SEQX_WRITE_A;
		end

		bundle.regAAddr = instrReg[9:8];
		bundle.regBAddr = instrReg[7:5];
		bundle.dataBus = `DATA_BUSX_ALU_R;
		bundle.regADin = `REGA_DINX_ALU_R;

		bundle.addrBus = `ADDR_BUSX_PC_A;
		bundle.byteSel = `BYTEX_WORD;
		bundle.pcBase = `PC_BASEX_PC_A;
		bundle.pcOffset = `PC_OFFSETX_2;
		bundle.rd = `RDX_NONE;
		bundle.wr = `WRX_NONE;
	end

endmodule

// ==== loadStoreDecoder.sv ====
`timescale 1ns/1ns
`include "opx_settings.svh"

module loadStoreDecoder (
	input opxPkg::instrT instrReg,
	opxBundleIf.decoder bundle
);
	import opxPkg::*;

	opcodeT opcode;
	logic immFlag;
	logic isStore;

	assign opcode = instrReg[13:10];
	assign immFlag = instrReg[4];
	assign isStore = opcode[0]; // 0 load, 1 store

	always_comb begin
		bundle.addrBus = `ADDR_BUSX_REG_B; // memory address from regB
		bundle.aluOp = `ALU_OPX_MOV;
		bundle.aluASrc = `ALUA_SRCX_REG_A;
		bundle.aluBSrc = immFlag ? `ALUB_SRCX_IMM : `ALUB_SRCX_REG_B;
		bundle.byteSel = opcode[1];
		bundle.cclLoad = 1'b0;
		bundle.pcBase = `PC_BASEX_PC_A;
		bundle.pcOffset = `PC_OFFSETX_2;
		bundle.regAAddr = instrReg[9:8];
		bundle.regBAddr = instrReg[7:5];
		bundle.regADin = `REGA_DINX_DIN;

		if (isStore) begin
			bundle.rd = `RDX_NONE;
			bundle.wr = 1'b1;
			bundle.regSeq = `REG_SEQX_NONE;
			bundle.dataBus = `DATA_BUSX_REGA_DOUT; // regA drives memory
		end else begin
			bundle.rd = 1'b1;
			bundle.wr = `WRX_NONE;
			bundle.regSeq = `REG_SEQX_WRITE_A; // memory word back into regA
			bundle.dataBus = `DATA_BUSX_MEM;
		end
	end

endmodule

// ==== jumpDecoder.sv ====
`timescale 1ns/1ns
`include "opx_settings.svh"

module jumpDecoder (
	input opxPkg::instrT instrReg,
	opxBundleIf.decoder bundle
);
	import opxPkg::*;

	opcodeT opcode;
	logic immFlag;
	logic isIndirect;
	logic isLink;

	assign opcode = instrReg[13:10];
	assign immFlag = instrReg[4];
	assign isIndirect = opcode[0];
	assign isLink = opcode[1];

	always_comb begin
		if (isIndirect) begin
			bundle.pcBase = `PC_BASEX_REG_B; // target taken from regB
			bundle.pcOffset = 2'd0;
			bundle.addrBus = `ADDR_BUSX_REG_B;
		end else begin
			bundle.pcBase = `PC_BASEX_PC_A;
			bundle.pcOffset = `PC_OFFSETX_IMM; // pc relative
			bundle.addrBus = `ADDR_BUSX_PC_A;
		end

		// link saves the return pc in regA
		bundle.regSeq = isLink ? `REG_SEQX_WRITE_A : `REG_SEQX_NONE;
		bundle.regADin = isLink ? `REGA_DINX_PC : `REGA_DINX_DIN;

		bundle.aluBSrc = immFlag ? `ALUB_SRCX_IMM : `ALUB_SRCX_REG_B;
		bundle.rd = `RDX_NONE;
		bundle.aluOp = `ALU_OPX_MOV;
		bundle.aluASrc = `ALUA_SRCX_REG_A;
		bundle.byteSel = `BYTEX_WORD;
		bundle.cclLoad = 1'b0;
		bundle.dataBus = `DATA_BUSX_REGA_DOUT;
		bundle.regAAddr = `REGA_ADDRX_ARGA;
		bundle.regBAddr = `REGB_ADDRX_ARGB;
		bundle.wr = `WRX_NONE;
	end

endmodule

// ==== phaseSequencer.sv ====
`timescale 1ns/1ns

module phaseSequencer (
	input logic CLK,
	input logic RESET,
	input opxPkg::instrT instr,
	input logic instrValid,
	output opxPkg::instrT instrReg,
	output logic fetch,
	output logic execute
);
	import opxPkg::*;

	phaseT phase;

	//////////////////////////////////////////////////////////////////////
	// fetch / execute alternation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= phFetch;
			instrReg <= '0; // decodes as system group
		end else begin
			case (phase)
				phFetch: begin
					if (instrValid) begin // wait here for the source
						instrReg <= instr;
						phase <= phExecute;
					end
				end
				phExecute: begin
					phase <= phFetch; // always a single execute cycle
				end
			endcase
		end
	end

	assign fetch = (phase == phFetch);
	assign execute = (phase == phExecute);

endmodule

// ==== opxMultiplexer.sv ====
`timescale 1ns/1ns
`include "opx_settings.svh"

module opxMultiplexer (
	input logic CLK,
	input logic RESET,
	input logic fetch,
	input logic execute,
	input opxPkg::groupT group,
	opxBundleIf.mux aluBundle,
	opxBundleIf.mux ldsBundle,
	opxBundleIf.mux jmpBundle,
	output opxPkg::busSelT addrBus,
	output opxPkg::busSelT pcBase,
	output opxPkg::busSelT pcOffset,
	output opxPkg::aluOpT aluOp,
	output opxPkg::srcSelT aluASrc,
	output opxPkg::srcSelT aluBSrc,
	output logic byteSel,
	output logic cclLoad,
	output opxPkg::busSelT dataBus,
	output logic rd,
	output opxPkg::busSelT regAAddr,
	output opxPkg::busSelT regADin,
	output opxPkg::regSeqT regSeq,
	output opxPkg::regBSelT regBAddr,
	output logic wr
);
	import opxPkg::*;

	busSelT selAddrBus;
	busSelT selPcBase;
	busSelT selPcOffset;

	//////////////////////////////////////////////////////////////////////
	// field selection by group
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (group)
			`GROUP_LOAD_STORE: begin
				selAddrBus = ldsBundle.addrBus;
				selPcBase = ldsBundle.pcBase;
				selPcOffset = ldsBundle.pcOffset;
				aluOp = ldsBundle.aluOp;
				aluASrc = ldsBundle.aluASrc;
				aluBSrc = ldsBundle.aluBSrc;
				byteSel = ldsBundle.byteSel;
				cclLoad = ldsBundle.cclLoad;
				dataBus = ldsBundle.dataBus;
				rd = ldsBundle.rd;
				regAAddr = ldsBundle.regAAddr;
				regADin = ldsBundle.regADin;
				regSeq = ldsBundle.regSeq;
				regBAddr = ldsBundle.regBAddr;
				wr = ldsBundle.wr;
			end
			`GROUP_JUMP: begin
				selAddrBus = jmpBundle.addrBus;
				selPcBase = jmpBundle.pcBase;
				selPcOffset = jmpBundle.pcOffset;
				aluOp = jmpBundle.aluOp;
				aluASrc = jmpBundle.aluASrc;
				aluBSrc = jmpBundle.aluBSrc;
				byteSel = jmpBundle.byteSel;
				cclLoad = jmpBundle.cclLoad;
				dataBus = jmpBundle.dataBus;
				rd = jmpBundle.rd;
				regAAddr = jmpBundle.regAAddr;
				regADin = jmpBundle.regADin;
				regSeq = jmpBundle.regSeq;
				regBAddr = jmpBundle.regBAddr;
				wr = jmpBundle.wr;
			end
			`GROUP_ARITHMETIC_LOGIC: begin
				selAddrBus = aluBundle.addrBus;
				selPcBase = aluBundle.pcBase;
				selPcOffset = aluBundle.pcOffset;
				aluOp = aluBundle.aluOp;
				aluASrc = aluBundle.aluASrc;
				aluBSrc = aluBundle.aluBSrc;
				byteSel = aluBundle.byteSel;
				cclLoad = aluBundle.cclLoad;
				dataBus = aluBundle.dataBus;
				rd = aluBundle.rd;
				regAAddr = aluBundle.regAAddr;
				regADin = aluBundle.regADin;
				regSeq = aluBundle.regSeq;
				regBAddr = aluBundle.regBAddr;
				wr = aluBundle.wr;
			end
			default: begin // system group, fixed defaults
				selAddrBus = `ADDR_BUSX_PC_A;
				selPcBase = `PC_BASEX_PC_A;
				selPcOffset = `PC_OFFSETX_2;
				aluOp = `ALU_OPX_MOV;
				aluASrc = `ALUA_SRCX_REG_A;
				aluBSrc = `ALUB_SRCX_REG_B;
				byteSel = `BYTEX_WORD;
				cclLoad = 1'b0;
				dataBus = `DATA_BUSX_REGA_DOUT;
				rd = `RDX_NONE;
				regAAddr = `REGA_ADDRX_ARGA;
				regADin = `REGA_DINX_DIN;
				regSeq = `REG_SEQX_NONE;
				regBAddr = `REGB_ADDRX_ARGB;
				wr = `WRX_NONE;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// next address fields, held through the following fetch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			addrBus <= `ADDR_BUSX_PC_A;
			pcBase <= `PC_BASEX_PC_A;
			pcOffset <= `PC_OFFSETX_2;
		end else if (fetch) begin // back to pc + 2 for the next fetch
			addrBus <= `ADDR_BUSX_PC_A;
			pcBase <= `PC_BASEX_PC_A;
			pcOffset <= `PC_OFFSETX_2;
		end else if (execute) begin
			addrBus <= selAddrBus;
			pcBase <= selPcBase;
			pcOffset <= selPcOffset;
		end
	end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
	input logic CLK,
	input logic RESET,
	input opxPkg::instrT instr,
	input logic instrValid,
	output logic fetch,
	output logic execute,
	output opxPkg::busSelT addrBus,
	output opxPkg::aluOpT aluOp,
	output opxPkg::srcSelT aluASrc,
	output opxPkg::srcSelT aluBSrc,
	output logic byteSel,
	output logic cclLoad,
	output opxPkg::busSelT dataBus,
	output opxPkg::busSelT pcBase,
	output opxPkg::busSelT pcOffset,
	output logic rd,
	output opxPkg::busSelT regAAddr,
	output opxPkg::busSelT regADin,
	output opxPkg::regSeqT regSeq,
	output opxPkg::regBSelT regBAddr,
	output logic wr
);
	import opxPkg::*;

	instrT instrReg;
	groupT group;

	assign group = instrReg[15:14];

	phaseSequencer sequencer (
		.CLK(CLK),
		.RESET(RESET),
		.instr(instr),
		.instrValid(instrValid),
		.instrReg(instrReg),
		.fetch(fetch),
		.execute(execute)
	);

	//////////////////////////////////////////////////////////////////////
	// group decoders
	//////////////////////////////////////////////////////////////////////

	opxBundleIf aluBundle ();
	opxBundleIf ldsBundle ();
	opxBundleIf jmpBundle ();

	aluGroupDecoder aluDecoder (.instrReg(instrReg), .bundle(aluBundle));
	loadStoreDecoder ldsDecoder (.instrReg(instrReg), .bundle(ldsBundle));
	jumpDecoder jmpDecoder (.instrReg(instrReg), .bundle(jmpBundle));

	opxMultiplexer mux (
		.CLK(CLK),
		.RESET(RESET),
		.fetch(fetch),
		.execute(execute),
		.group(group),
		.aluBundle(aluBundle),
		.ldsBundle(ldsBundle),
		.jmpBundle(jmpBundle),
		.addrBus(addrBus),
		.pcBase(pcBase),
		.pcOffset(pcOffset),
		.aluOp(aluOp),
		.aluASrc(aluASrc),
		.aluBSrc(aluBSrc),
		.byteSel(byteSel),
		.cclLoad(cclLoad),
		.dataBus(dataBus),
		.rd(rd),
		.regAAddr(regAAddr),
		.regADin(regADin),
		.regSeq(regSeq),
		.regBAddr(regBAddr),
		.wr(wr)
	);

endmodule

// ==== controlUnitTb.sv ====
`timescale 1ns/1ns
`include "opx_settings.svh"

module controlUnitTb;
	import opxPkg::*;

	localparam int waitLimit = 40; // cycles before a wait gives up
	localparam int randomWords = 300;

	typedef struct packed {
		busSelT addrBus;
		aluOpT aluOp;
		srcSelT aluASrc;
		srcSelT aluBSrc;
		logic byteSel;
		logic cclLoad;
		busSelT dataBus;
		busSelT pcBase;
		busSelT pcOffset;
		logic rd;
		busSelT regAAddr;
		busSelT regADin;
		regSeqT regSeq;
		regBSelT regBAddr;
		logic wr;
	} fieldsT;

	logic CLK;
	logic RESET;
	instrT instr;
	logic instrValid;
	logic fetch;
	logic execute;
	busSelT addrBus;
	aluOpT aluOp;
	srcSelT aluASrc;
	srcSelT aluBSrc;
	logic byteSel;
	logic cclLoad;
	busSelT dataBus;
	busSelT pcBase;
	busSelT pcOffset;
	logic rd;
	busSelT regAAddr;
	busSelT regADin;
	regSeqT regSeq;
	regBSelT regBAddr;
	logic wr;

	logic [15:0] lfsrState;
	instrT pendingQ[$]; // words still to be offered
	instrT acceptedQ[$]; // words taken by the DUT, waiting for execute
	instrT curInstr;
	int errs[5]; // reset, phase, comb fields, registered fields, directed
	int checks;
	int combTest;
	int regTest;
	bit aborted;

	controlUnit controlUnit_inst (.*);

	always #2 CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// stimulus source and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return v;
	endfunction

	function automatic fieldsT expectedFields(input instrT w);
		fieldsT f;
		opcodeT op;
		op = w[13:10];
		f.addrBus = `ADDR_BUSX_PC_A;
		f.aluOp = `ALU_OPX_MOV;
		f.aluASrc = `ALUA_SRCX_REG_A;
		f.aluBSrc = w[4] ? `ALUB_SRCX_IMM : `ALUB_SRCX_REG_B;
		f.byteSel = `BYTEX_WORD;
		f.cclLoad = 1'b0;
		f.dataBus = `DATA_BUSX_REGA_DOUT;
		f.pcBase = `PC_BASEX_PC_A;
		f.pcOffset = `PC_OFFSETX_2;
		f.rd = `RDX_NONE;
		f.regAAddr = `REGA_ADDRX_ARGA;
		f.regADin = `REGA_DINX_DIN;
		f.regSeq = `REG_SEQX_NONE;
		f.regBAddr = `REGB_ADDRX_ARGB;
		f.wr = `WRX_NONE;
		case (w[15:14])
			`GROUP_ARITHMETIC_LOGIC: begin
				f.aluOp = op;
				f.cclLoad = (op != `ALU_OPX_MOV);
				f.regSeq = (op == `ALU_OPX_CMP) ? `REG_SEQX_NONE : `REG_SEQX_WRITE_A;
				f.regAAddr = w[9:8];
				f.regBAddr = w[7:5];
				f.dataBus = `DATA_BUSX_ALU_R;
				f.regADin = `REGA_DINX_ALU_R;
			end
			`GROUP_LOAD_STORE: begin
				f.addrBus = `ADDR_BUSX_REG_B;
				f.byteSel = op[1];
				f.regAAddr = w[9:8];
				f.regBAddr = w[7:5];
				f.wr = op[0];
				f.rd = ~op[0];
				f.dataBus = op[0] ? `DATA_BUSX_REGA_DOUT : `DATA_BUSX_MEM;
				f.regSeq = op[0] ? `REG_SEQX_NONE : `REG_SEQX_WRITE_A;
			end
			`GROUP_JUMP: begin
				f.pcBase = op[0] ? `PC_BASEX_REG_B : `PC_BASEX_PC_A;
				f.pcOffset = op[0] ? 2'd0 : `PC_OFFSETX_IMM;
				f.addrBus = op[0] ? `ADDR_BUSX_REG_B : `ADDR_BUSX_PC_A;
				f.regSeq = op[1] ? `REG_SEQX_WRITE_A : `REG_SEQX_NONE;
				f.regADin = op[1] ? `REGA_DINX_PC : `REGA_DINX_DIN;
			end
			default: begin
				f.aluBSrc = `ALUB_SRCX_REG_B; // system group ignores the immediate flag
			end
		endcase
		return f;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected, input int test);
		checks++;
		if (actual !== expected) begin
			$display("ERR %0t ns: %s is %0d, expected %0d for instr %h", $time, name,
				actual, expected, curInstr);
			errs[test]++;
		end
	endtask

	task automatic checkPhase(input logic expectExec);
		checks++;
		if (execute !== expectExec || fetch !== !expectExec) begin
			$display("ERR %0t ns: execute %b fetch %b, expected execute %b", $time,
				execute, fetch, expectExec);
			errs[1]++;
		end
	endtask

	task automatic compareComb(input fieldsT f);
		checkValue("aluOp", 32'(aluOp), 32'(f.aluOp), combTest);
		checkValue("aluASrc", 32'(aluASrc), 32'(f.aluASrc), combTest);
		checkValue("aluBSrc", 32'(aluBSrc), 32'(f.aluBSrc), combTest);
		checkValue("byteSel", 32'(byteSel), 32'(f.byteSel), combTest);
		checkValue("cclLoad", 32'(cclLoad), 32'(f.cclLoad), combTest);
		checkValue("dataBus", 32'(dataBus), 32'(f.dataBus), combTest);
		checkValue("rd", 32'(rd), 32'(f.rd), combTest);
		checkValue("regAAddr", 32'(regAAddr), 32'(f.regAAddr), combTest);
		checkValue("regADin", 32'(regADin), 32'(f.regADin), combTest);
		checkValue("regSeq", 32'(regSeq), 32'(f.regSeq), combTest);
		checkValue("regBAddr", 32'(regBAddr), 32'(f.regBAddr), combTest);
		checkValue("wr", 32'(wr), 32'(f.wr), combTest);
	endtask

	task automatic compareReg(input fieldsT f);
		checkValue("addrBus", 32'(addrBus), 32'(f.addrBus), regTest);
		checkValue("pcBase", 32'(pcBase), 32'(f.pcBase), regTest);
		checkValue("pcOffset", 32'(pcOffset), 32'(f.pcOffset), regTest);
	endtask

	//////////////////////////////////////////////////////////////////////
	// driving and comparing processes
	//////////////////////////////////////////////////////////////////////

	task automatic driveWords();
		int idle;
		logic accepted;
		idle = 0;
		accepted = 1'b0;
		while (pendingQ.size() > 0 && idle < waitLimit && !aborted) begin
			@(negedge CLK);
			checkPhase(accepted); // a word taken last cycle means execute now
			accepted = 1'b0;
			instrValid = (takeBits(1) != 16'd0);
			if (fetch && instrValid) begin
				instr = pendingQ.pop_front();
				acceptedQ.push_back(instr);
				accepted = 1'b1;
				idle = 0;
			end else begin
				instr = takeBits(16); // junk, must be ignored
				idle++;
			end
		end
		if (idle >= waitLimit) begin
			$display("timeout: the DUT took no word within %0d cycles", waitLimit);
			errs[1]++;
			aborted = 1'b1;
		end
		repeat (3) begin
			@(negedge CLK);
			checkPhase(accepted);
			accepted = 1'b0;
			instrValid = 1'b0;
		end
	endtask

	task automatic compareWords(input int count);
		int n;
		int waited;
		fieldsT f;
		for (n = 0; n < count && !aborted; n++) begin
			waited = 0;
			while (execute !== 1'b1 && waited < waitLimit) begin
				@(negedge CLK);
				waited++;
			end
			if (execute !== 1'b1 || acceptedQ.size() == 0) begin
				$display("timeout: no execute cycle for accepted word %0d", n);
				errs[1]++;
				aborted = 1'b1;
			end else begin
				curInstr = acceptedQ.pop_front();
				f = expectedFields(curInstr);
				compareComb(f);
				@(negedge CLK);
				compareReg(f); // visible in the fetch after execute
				@(negedge CLK);
				compareReg(expectedFields(16'h0000)); // back to pc + 2
			end
		end
	endtask

	task automatic runWords(input int count);
		fork
			driveWords();
			compareWords(count);
		join
	endtask

	task automatic reportTest(input string name, input int idx);
		$display("%s: %s, %0d errors", name, (errs[idx] == 0) ? "ok" : "FAILED", errs[idx]);
	endtask

	initial begin
		int n;
		int total;
		CLK = 1'b0;
		RESET = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		lfsrState = 16'd4468;
		curInstr = '0;
		checks = 0;
		aborted = 1'b0;
		for (n = 0; n < 5; n++) begin
			errs[n] = 0;
		end
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;

		checkValue("fetch", 32'(fetch), 32'(1'b1), 0);
		checkValue("execute", 32'(execute), 32'(1'b0), 0);
		checkValue("rd", 32'(rd), 32'(`RDX_NONE), 0);
		checkValue("wr", 32'(wr), 32'(`WRX_NONE), 0);
		checkValue("addrBus", 32'(addrBus), 32'(`ADDR_BUSX_PC_A), 0);
		checkValue("pcBase", 32'(pcBase), 32'(`PC_BASEX_PC_A), 0);
		checkValue("pcOffset", 32'(pcOffset), 32'(`PC_OFFSETX_2), 0);
		reportTest("reset state", 0);

		// mov, cmp, byte load, indirect linked jump
		pendingQ.push_back(16'hC150);
		pendingQ.push_back(16'hDE20);
		pendingQ.push_back(16'h4BA0);
		pendingQ.push_back(16'h8CD0);
		combTest = 4;
		regTest = 4;
		runWords(4);
		reportTest("directed edge cases", 4);

		for (n = 0; n < randomWords; n++) begin
			pendingQ.push_back(takeBits(16));
		end
		combTest = 2;
		regTest = 3;
		runWords(randomWords);
		reportTest("phase sequencing", 1);
		reportTest("decoded fields", 2);
		reportTest("registered fields", 3);

		total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
		$display("checks %0d, errors %0d", checks, total);
		if (total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
opxPkg.sv
opxBundleIf.sv
aluGroupDecoder.sv
loadStoreDecoder.sv
jumpDecoder.sv
phaseSequencer.sv
opxMultiplexer.sv
controlUnit.sv
controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= controlUnitTb
RTL_TOP ?= controlUnit
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
